// ==== src.f ====
huff_pkg.sv
hist_clear.sv
hist_access.sv
path_burst.sv
sram_mux.sv
sram_if_top.sv
sram_if_props.sv
tb_sram_if.sv

// ==== run.sh ====
#!/bin/sh
# builds and runs the SRAM sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_sram_if -f src.f -o tb_sram_if
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sram_if > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation PASSED$" sim.log; then
    exit 0
fi
exit 1

// ==== tb_sram_if.sv ====
`timescale 1ns/1ps

module tb_sram_if;

    localparam int HIST_WORDS = 128;
    localparam int INDEX_BITS = 7;
    localparam int MEM_WORDS  = 512;   // all 128 codebook entries
    localparam int TIMEOUT    = 2000;  // cycles per wait
    localparam huff_pkg::path_t CB_PATH = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;

    logic                  clk;
    logic                  rst;
    huff_pkg::mode_e       mode_i;
    huff_pkg::hist_req_t   hist_req_i;
    logic                  cb_start_i;
    logic [INDEX_BITS-1:0] cb_index_i;
    huff_pkg::path_t       cb_path_i;
    logic                  trn_start_i;
    logic [INDEX_BITS-1:0] trn_index_i;
    huff_pkg::mem_rsp_t    mem_rsp_i;
    huff_pkg::mem_req_t    mem_req_o;
    logic                  clear_done_o;
    logic                  hist_done_o;
    logic [31:0]           hist_rdata_o;
    logic                  cb_done_o;
    logic                  trn_done_o;
    huff_pkg::path_t       path_o;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] ref_mem [MEM_WORDS];   // expected SRAM contents
    logic [31:0] wr_addr_q [$];         // write log of the SRAM model
    logic [31:0] wr_data_q [$];
    int          errors;

    sram_if_top #(.HIST_WORDS(HIST_WORDS), .INDEX_BITS(INDEX_BITS)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] fill_word(input int slot);
        return 32'hc0de_0000 ^ (32'(slot) * 32'h0001_0003);
    endfunction

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %0h expected %0h", name, got, exp);
        end
    endtask

    task automatic wait_done(input int sel, input string name);
        logic hit;
        for (int i = 0; i < TIMEOUT; i++) begin
            @(negedge clk);
            case (sel)
                0:       hit = clear_done_o;
                1:       hit = hist_done_o;
                2:       hit = cb_done_o;
                default: hit = trn_done_o;
            endcase
            if (hit) return;
        end
        errors++;
        $display("timeout waiting for %s", name);
    endtask

    // SRAM model, busy rises one cycle after the request
    task automatic serve_request();
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        wr;
        int          slot;
        int          len;
        addr  = mem_req_o.addr;
        wdata = mem_req_o.wdata;
        wr    = mem_req_o.we;
        len   = 1 + int'($urandom % 4);
        slot  = 0;
        if (addr - huff_pkg::HIST_BASE >= 32'(MEM_WORDS * 4) || addr[1:0] != 2'b00) begin
            errors++;
            $display("request to address %h outside the SRAM model", addr);
        end else begin
            slot = int'((addr - huff_pkg::HIST_BASE) >> 2);
        end
        @(negedge clk);
        mem_rsp_i.busy = 1'b1;
        if (wr) begin
            mem[slot] = wdata;
            wr_addr_q.push_back(addr);
            wr_data_q.push_back(wdata);
        end
        repeat (len) @(negedge clk);
        mem_rsp_i.rdata = wr ? 32'h0 : mem[slot];
        mem_rsp_i.busy  = 1'b0;
    endtask

    always begin
        @(negedge clk);
        if (!rst && !mem_rsp_i.busy && (mem_req_o.we || mem_req_o.re)) serve_request();
    end

    task automatic hist_cmd(input logic wr, input logic [7:0] idx, input logic [31:0] data);
        @(negedge clk);
        mode_i           = huff_pkg::MODE_HIST;
        hist_req_i.start = 1'b1;
        hist_req_i.write = wr;
        hist_req_i.index = idx;
        hist_req_i.data  = data;
        @(negedge clk);
        hist_req_i.start = 1'b0;
        wait_done(1, "hist_done_o");
        if (wr) ref_mem[int'(idx)] = data;
        else check("hist_rdata_o", 128'(hist_rdata_o), 128'(ref_mem[int'(idx)]));
    endtask

    task automatic write_path(input logic [INDEX_BITS-1:0] idx, input huff_pkg::path_t p);
        int base;
        base = int'(idx) * huff_pkg::PATH_WORDS;
        wr_addr_q.delete();
        wr_data_q.delete();
        @(negedge clk);
        mode_i     = huff_pkg::MODE_CODEBOOK;
        cb_start_i = 1'b1;
        cb_index_i = idx;
        cb_path_i  = p;
        @(negedge clk);
        cb_start_i = 1'b0;
        wait_done(2, "cb_done_o");
        check("codebook write count", 128'(wr_addr_q.size()), 128'(4));
        for (int k = 0; k < 4; k++) begin
            ref_mem[base + k] = p[127 - 32 * k -: 32];   // msw first
            if (k < wr_addr_q.size()) begin
                check("mem_req_o.addr", 128'(wr_addr_q[k]),
                      128'(huff_pkg::HIST_BASE + 32'((base + k) * 4)));
                check("mem_req_o.wdata", 128'(wr_data_q[k]), 128'(p[127 - 32 * k -: 32]));
            end
        end
    endtask

    task automatic read_path(input logic [INDEX_BITS-1:0] idx);
        int base;
        base = int'(idx) * huff_pkg::PATH_WORDS;
        @(negedge clk);
        mode_i      = huff_pkg::MODE_TRANSLATE;
        trn_start_i = 1'b1;
        trn_index_i = idx;
        @(negedge clk);
        trn_start_i = 1'b0;
        wait_done(3, "trn_done_o");
        check("path_o", path_o,
              {ref_mem[base], ref_mem[base + 1], ref_mem[base + 2], ref_mem[base + 3]});
    endtask

    task automatic reset_and_clear();
        repeat (8) @(negedge clk);
        check("mem_req_o.we", 128'(mem_req_o.we), '0);
        check("mem_req_o.re", 128'(mem_req_o.re), '0);
        check("clear_done_o", 128'(clear_done_o), '0);
        check("hist_done_o", 128'(hist_done_o), '0);
        check("cb_done_o", 128'(cb_done_o), '0);
        check("trn_done_o", 128'(trn_done_o), '0);
        check("hist_rdata_o", 128'(hist_rdata_o), '0);
        check("path_o", path_o, '0);
        rst    = 1'b0;
        mode_i = huff_pkg::MODE_HIST;   // sweep starts here
        wait_done(0, "clear_done_o");
        check("sweep write count", 128'(wr_addr_q.size()), 128'(HIST_WORDS));
        for (int n = 0; n < HIST_WORDS && n < wr_addr_q.size(); n++) begin
            check("mem_req_o.addr", 128'(wr_addr_q[n]), 128'(huff_pkg::HIST_BASE + 32'(n * 4)));
            check("mem_req_o.wdata", 128'(wr_data_q[n]), '0);
            ref_mem[n] = 32'h0;
        end
        repeat (5) @(negedge clk);
        check("clear_done_o", 128'(clear_done_o), 128'(1));
    endtask

    task automatic hist_roundtrip();
        hist_cmd(1'b1, 8'd5, 32'h1234_abcd);
        hist_cmd(1'b0, 8'd5, 32'h0);
        check("hist_rdata_o", 128'(hist_rdata_o), 128'(32'h1234_abcd));
        hist_cmd(1'b0, 8'd9, 32'h0);
        check("hist_rdata_o", 128'(hist_rdata_o), '0);
    endtask

    task automatic random_mix();
        logic [7:0]      idx;
        huff_pkg::path_t p;
        int              op;
        for (int n = 0; n < 40; n++) begin
            op  = int'($urandom % 4);
            idx = 8'($urandom);
            p   = {$urandom, $urandom, $urandom, $urandom};
            case (op)
                0:       hist_cmd(1'b1, idx, $urandom);
                1:       hist_cmd(1'b0, idx, 32'h0);
                2:       write_path(idx[INDEX_BITS-1:0], p);
                default: read_path(idx[INDEX_BITS-1:0]);
            endcase
        end
    endtask

    initial begin
        void'($urandom(32'hb990_45f3));
        errors      = 0;
        rst         = 1'b1;
        mode_i      = huff_pkg::MODE_IDLE;
        hist_req_i  = '0;
        cb_start_i  = 1'b0;
        cb_index_i  = '0;
        cb_path_i   = '0;
        trn_start_i = 1'b0;
        trn_index_i = '0;
        mem_rsp_i   = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]     = fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        reset_and_clear();
        hist_roundtrip();
        write_path(7'd3, CB_PATH);
        read_path(7'd3);
        check("path_o", path_o, CB_PATH);
        random_mix();
        check("clear_done_o", 128'(clear_done_o), 128'(1));
        $display("run complete with %0d errors", errors);
        if (errors == 0) $display("Simulation PASSED");
        else $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== sram_if_props.sv ====
`timescale 1ns/1ps

module sram_if_props (
    input logic               clk,
    input logic               rst,
    input huff_pkg::mem_req_t mem_req_o,
    input huff_pkg::mem_rsp_t mem_rsp_i,
    input logic               hist_done_o,
    input logic               cb_done_o,
    input logic               trn_done_o
);

    one_direction: assert property (@(posedge clk) disable iff (rst)
        !(mem_req_o.we && mem_req_o.re)) else $error("we and re high together");

    no_req_when_busy: assert property (@(posedge clk) disable iff (rst)
        mem_rsp_i.busy |-> !(mem_req_o.we || mem_req_o.re))
        else $error("request issued while busy");

    // done outputs are single-cycle pulses
    hist_done_pulse: assert property (@(posedge clk) disable iff (rst)
        hist_done_o |=> !hist_done_o) else $error("hist_done_o held for two cycles");
    cb_done_pulse: assert property (@(posedge clk) disable iff (rst)
        cb_done_o |=> !cb_done_o) else $error("cb_done_o held for two cycles");
    trn_done_pulse: assert property (@(posedge clk) disable iff (rst)
        trn_done_o |=> !trn_done_o) else $error("trn_done_o held for two cycles");

endmodule

bind sram_if_top sram_if_props u_props (.*);

// ==== sram_if_top.sv ====
`timescale 1ns/1ps

module sram_if_top #(
    parameter int HIST_WORDS = 128,
    parameter int INDEX_BITS = 7
) (
    input  logic                  clk,
    input  logic                  rst,
    input  huff_pkg::mode_e       mode_i,
    input  huff_pkg::hist_req_t   hist_req_i,
    input  logic                  cb_start_i,
    input  logic [INDEX_BITS-1:0] cb_index_i,
    input  huff_pkg::path_t       cb_path_i,
    input  logic                  trn_start_i,
    input  logic [INDEX_BITS-1:0] trn_index_i,
    input  huff_pkg::mem_rsp_t    mem_rsp_i,
    output huff_pkg::mem_req_t    mem_req_o,
    output logic                  clear_done_o,
    output logic                  hist_done_o,
    output logic [31:0]           hist_rdata_o,
    output logic                  cb_done_o,
    output logic                  trn_done_o,
    output huff_pkg::path_t       path_o
);

    huff_pkg::mem_req_t    clear_req;
    huff_pkg::mem_req_t    hist_req;
    huff_pkg::mem_req_t    path_req;
    logic                  busy_fall;
    logic [31:0]           rdata;
    logic                  burst_start;
    logic [INDEX_BITS-1:0] burst_index;
    logic                  burst_done;

    // one burst engine, codebook writes and translation reads
    assign burst_start = cb_start_i | trn_start_i;
    assign burst_index = cb_start_i ? cb_index_i : trn_index_i;

    assign cb_done_o  = burst_done & (mode_i == huff_pkg::MODE_CODEBOOK);
    assign trn_done_o = burst_done & (mode_i == huff_pkg::MODE_TRANSLATE);

    hist_clear #(.HIST_WORDS(HIST_WORDS)) u_clear (
        .clk          (clk),
        .rst          (rst),
        .mode_i       (mode_i),
        .busy_fall_i  (busy_fall),
        .req_o        (clear_req),
        .clear_done_o (clear_done_o)
    );

    hist_access u_hist (
        .clk         (clk),
        .rst         (rst),
        .hist_req_i  (hist_req_i),
        .busy_fall_i (busy_fall),
        .rdata_i     (rdata),
        .req_o       (hist_req),
        .done_o      (hist_done_o),
        .rdata_o     (hist_rdata_o)
    );

    path_burst #(.INDEX_BITS(INDEX_BITS)) u_burst (
        .clk         (clk),
        .rst         (rst),
        .start_i     (burst_start),
        .write_i     (cb_start_i),   // write for codebook, read otherwise
        .index_i     (burst_index),
        .path_i      (cb_path_i),
        .busy_fall_i (busy_fall),
        .rdata_i     (rdata),
        .req_o       (path_req),
        .done_o      (burst_done),
        .path_o      (path_o)
    );

    sram_mux u_mux (
        .clk          (clk),
        .rst          (rst),
        .mode_i       (mode_i),
        .clear_done_i (clear_done_o),
        .clear_req_i  (clear_req),
        .hist_req_i   (hist_req),
        .path_req_i   (path_req),
        .mem_rsp_i    (mem_rsp_i),
        .mem_req_o    (mem_req_o),
        .busy_fall_o  (busy_fall),
        .rdata_o      (rdata)
    );

endmodule

// ==== sram_mux.sv ====
`timescale 1ns/1ps

module sram_mux (
    input  logic               clk,
    input  logic               rst,
    input  huff_pkg::mode_e    mode_i,
    input  logic               clear_done_i,
    input  huff_pkg::mem_req_t clear_req_i,
    input  huff_pkg::mem_req_t hist_req_i,
    input  huff_pkg::mem_req_t path_req_i,
    input  huff_pkg::mem_rsp_t mem_rsp_i,
    output huff_pkg::mem_req_t mem_req_o,
    output logic               busy_fall_o,
    output logic [31:0]        rdata_o
);

    logic busy_q;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) busy_q <= 1'b0;
        else     busy_q <= mem_rsp_i.busy;
    end

    // completion cycle, busy high last cycle and low now
    assign busy_fall_o = busy_q & ~mem_rsp_i.busy;
    assign rdata_o     = mem_rsp_i.rdata;

    always_comb begin
        mem_req_o = '0;
        if (!clear_done_i) begin
            mem_req_o = clear_req_i;   // sweep owns the port first
        end else begin
            case (mode_i)
                huff_pkg::MODE_HIST:      mem_req_o = hist_req_i;
                huff_pkg::MODE_CODEBOOK,
                huff_pkg::MODE_TRANSLATE: mem_req_o = path_req_i;
                default:                  mem_req_o = '0;
            endcase
        end
    end

endmodule

// ==== path_burst.sv ====
`timescale 1ns/1ps

module path_burst #(
    parameter int INDEX_BITS = 7
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start_i,
    input  logic                  write_i,
    input  logic [INDEX_BITS-1:0] index_i,
    input  huff_pkg::path_t       path_i,
    input  logic                  busy_fall_i,
    input  logic [31:0]           rdata_i,
    output huff_pkg::mem_req_t    req_o,
    output logic                  done_o,
    output huff_pkg::path_t       path_o
);

    logic                  active;
    logic                  wait_ph;    // 0 issue, 1 wait for completion
    logic [1:0]            word_cnt;
    logic                  accept;
    logic                  last_word;
    logic [6:0]            slice_lo;   // low bit of the current word
    logic                  write_q;
    logic [INDEX_BITS-1:0] index_q;
    huff_pkg::path_t       path_q;
    logic [31:0]           entry_addr;

    assign accept    = start_i & ~active;
    assign last_word = (word_cnt == 2'(huff_pkg::PATH_WORDS - 1));

    // word k sits at bits (3-k)*32, msw first
    assign slice_lo = {~word_cnt, 5'd0};

    assign entry_addr = huff_pkg::HIST_BASE
                      + 32'(index_q) * (32'(huff_pkg::PATH_WORDS) * huff_pkg::WORD_BYTES);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            active   <= 1'b0;
            wait_ph  <= 1'b0;
            word_cnt <= '0;
            done_o   <= 1'b0;
            path_o   <= '0;
        end else begin
            done_o <= 1'b0;
            if (accept) begin
                active   <= 1'b1;
                wait_ph  <= 1'b0;
                word_cnt <= '0;
            end else if (active && !wait_ph) begin
                wait_ph <= 1'b1;
            end else if (active && busy_fall_i) begin
                wait_ph <= 1'b0;
                if (!write_q) begin
                    path_o[slice_lo +: 32] <= rdata_i;
                end
                if (last_word) begin
                    active <= 1'b0;
                    done_o <= 1'b1;
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            write_q <= write_i;
            index_q <= index_i;
            path_q  <= path_i;
        end
    end

    always_comb begin
        req_o       = '0;
        req_o.we    = active & ~wait_ph & write_q;
        req_o.re    = active & ~wait_ph & ~write_q;
        req_o.addr  = entry_addr + 32'(word_cnt) * huff_pkg::WORD_BYTES;
        req_o.wdata = path_q[slice_lo +: 32];
    end

endmodule

// ==== hist_access.sv ====
`timescale 1ns/1ps

module hist_access (
    input  logic                clk,
    input  logic                rst,
    input  huff_pkg::hist_req_t hist_req_i,
    input  logic                busy_fall_i,
    input  logic [31:0]         rdata_i,
    output huff_pkg::mem_req_t  req_o,
    output logic                done_o,
    output logic [31:0]         rdata_o
);

    typedef enum logic [1:0] {ST_IDLE, ST_ISSUE, ST_WAIT} state_e;

    state_e      state;
    logic        write_q;
    logic [7:0]  index_q;
    logic [31:0] data_q;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state   <= ST_IDLE;
            done_o  <= 1'b0;
            rdata_o <= '0;
        end else begin
            done_o <= 1'b0;
            case (state)
                ST_IDLE:  if (hist_req_i.start) state <= ST_ISSUE;
                ST_ISSUE: state <= ST_WAIT;
                ST_WAIT: begin
                    if (busy_fall_i) begin
                        state  <= ST_IDLE;
                        done_o <= 1'b1;
                        if (!write_q) rdata_o <= rdata_i;   // old count
                    end
                end
                default:  state <= ST_IDLE;
            endcase
        end
    end

    // command payload, taken only when idle
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && hist_req_i.start) begin
            write_q <= hist_req_i.write;
            index_q <= hist_req_i.index;
            data_q  <= hist_req_i.data;
        end
    end

    always_comb begin
        req_o       = '0;
        req_o.we    = (state == ST_ISSUE) & write_q;
        req_o.re    = (state == ST_ISSUE) & ~write_q;
        req_o.addr  = huff_pkg::HIST_BASE + 32'(index_q) * huff_pkg::WORD_BYTES;
        req_o.wdata = data_q;
    end

endmodule

// ==== hist_clear.sv ====
`timescale 1ns/1ps

module hist_clear #(
    parameter int HIST_WORDS = 128
) (
    input  logic               clk,
    input  logic               rst,
    input  huff_pkg::mode_e    mode_i,
    input  logic               busy_fall_i,
    output huff_pkg::mem_req_t req_o,
    output logic               clear_done_o
);

    localparam int CNT_BITS = (HIST_WORDS > 1) ? $clog2(HIST_WORDS) : 1;

    logic                running;
    logic                waiting;   // write sent, completion pending
    logic [CNT_BITS-1:0] word_cnt;
    logic                last_word;

    assign last_word = (word_cnt == CNT_BITS'(HIST_WORDS - 1));

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            running      <= 1'b0;
            waiting      <= 1'b0;
            word_cnt     <= '0;
            clear_done_o <= 1'b0;
        end else begin
            if (!running && !clear_done_o && mode_i == huff_pkg::MODE_HIST) begin
                running <= 1'b1;
            end else if (running && !waiting) begin
                waiting <= 1'b1;
            end else if (running && busy_fall_i) begin
                waiting  <= 1'b0;
                word_cnt <= word_cnt + 1'b1;
                if (last_word) begin
                    running      <= 1'b0;
                    clear_done_o <= 1'b1;   // sticky until reset
                end
            end
        end
    end

    always_comb begin
        req_o       = '0;
        req_o.we    = running & ~waiting;
        req_o.addr  = huff_pkg::HIST_BASE + 32'(word_cnt) * huff_pkg::WORD_BYTES;
        req_o.wdata = '0;   // sweep writes zeros
    end

endmodule

// ==== huff_pkg.sv ====
package huff_pkg;

    // controller state, codes follow the encoder's state numbering
    typedef enum logic [2:0] {
        MODE_IDLE      = 3'd0,
        MODE_HIST      = 3'd1,
        MODE_CODEBOOK  = 3'd4,
        MODE_TRANSLATE = 3'd5
    } mode_e;

    // histogram words, codebook entries share the same base
    localparam logic [31:0] HIST_BASE  = 32'h3300_1024;
    localparam logic [31:0] WORD_BYTES = 32'd4;
    localparam int          PATH_WORDS = 4;

    typedef logic [127:0] path_t;

    typedef struct packed {
        logic        we;
        logic        re;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic        busy;
        logic [31:0] rdata;
    } mem_rsp_t;

    // one command from the counting stage
    typedef struct packed {
        logic        start;
        logic        write;   // 1 write, 0 read
        logic [7:0]  index;
        logic [31:0] data;
    } hist_req_t;

endpackage
